// File: rtl/tim_config_pkg.sv
package tim_config_pkg;

  // geometry of the data memory.
  localparam int tim_width = 4;   // banks, one word wide.
  localparam int tim_depth = 64;  // words per bank.

  // byte offset inside a 32-bit word.
  localparam int byte_bits = 2;

  // select widths, derived from the geometry.
  localparam int bank_bits = $clog2(tim_width);
  localparam int row_bits = $clog2(tim_depth);

  // where the fields sit in a byte address.
  localparam int bank_lsb = byte_bits;
  localparam int row_lsb = byte_bits + bank_bits;

  // ram coding style.
  // 0: word array, bytes written through bit slices.
  // 1: packed array of four bytes per word.
  // both give the same behavior, the choice only changes what the
  // synthesis tool infers.
  localparam int tim_ram_style = 0;

endpackage

// File: rtl/tim_bus_pkg.sv
package tim_bus_pkg;

  // core-side bus widths.
  localparam int tim_addr_bits = 32;
  localparam int tim_data_bits = 32;
  localparam int tim_strb_bits = tim_data_bits / 8;  // one strobe per byte.

  // request from the core.
  // a request with wstrb all zero is a read.
  typedef struct packed {
    logic                     valid;
    logic [tim_addr_bits-1:0] addr;
    logic [tim_data_bits-1:0] wdata;
    logic [tim_strb_bits-1:0] wstrb;
  } tim_req_t;

  // response to the core, one cycle after the request.
  typedef struct packed {
    logic                     ready;
    logic [tim_data_bits-1:0] rdata;
  } tim_rsp_t;

endpackage

// File: rtl/tim_bank_if.sv
`timescale 1ns/10ps

interface tim_bank_if;

  logic                                    en;     // access this cycle.
  logic [tim_config_pkg::row_bits-1:0]     row;    // word inside the bank.
  logic [tim_bus_pkg::tim_strb_bits-1:0]   strb;   // byte write enables.
  logic [tim_bus_pkg::tim_data_bits-1:0]   wdata;
  logic [tim_bus_pkg::tim_data_bits-1:0]   rdata;  // registered, zero when idle.

  // controller side drives the request.
  modport ctrl (
    output en,
    output row,
    output strb,
    output wdata,
    input  rdata
  );

  // bank side returns the old word.
  modport bank (
    input  en,
    input  row,
    input  strb,
    input  wdata,
    output rdata
  );

endinterface

// File: rtl/tim_bank.sv
`timescale 1ns/10ps

module tim_bank (
  input logic      clock,
  tim_bank_if.bank port
);

  generate
    if (tim_config_pkg::tim_ram_style == 0) begin : g_word

      // one word per row, bytes reached through bit slices.
      logic [tim_bus_pkg::tim_data_bits-1:0] mem [tim_config_pkg::tim_depth] =
        '{default: '0};

      always_ff @(posedge clock) begin
        if (port.en) begin
          for (int b = 0; b < tim_bus_pkg::tim_strb_bits; b++) begin
            if (port.strb[b]) begin
              mem[port.row][8*b +: 8] <= port.wdata[8*b +: 8];
            end
          end
          port.rdata <= mem[port.row];  // old word, read before write.
        end else begin
          port.rdata <= '0;
        end
      end

    end else begin : g_bytes

      // packed bytes per row.
      logic [tim_bus_pkg::tim_strb_bits-1:0][7:0] mem [tim_config_pkg::tim_depth] =
        '{default: '0};
      logic [tim_bus_pkg::tim_strb_bits-1:0][7:0] wbytes;

      assign wbytes = port.wdata;

      always_ff @(posedge clock) begin
        if (port.en) begin
          for (int b = 0; b < tim_bus_pkg::tim_strb_bits; b++) begin
            if (port.strb[b]) begin
              mem[port.row][b] <= wbytes[b];
            end
          end
          port.rdata <= mem[port.row];
        end else begin
          // idle banks return zero, the select in the controller relies on it.
          port.rdata <= '0;
        end
      end

    end
  endgenerate

endmodule

// File: rtl/tim_ctrl.sv
`timescale 1ns/10ps

module tim_ctrl (
  input  logic                  clock,
  input  logic                  reset,
  input  tim_bus_pkg::tim_req_t req,
  output tim_bus_pkg::tim_rsp_t rsp,
  tim_bank_if.ctrl              banks [tim_config_pkg::tim_width]
);

  // request decode.
  logic [tim_config_pkg::bank_bits-1:0] bank_sel;
  logic [tim_config_pkg::row_bits-1:0]  row_sel;
  logic [tim_config_pkg::tim_width-1:0] bank_en;

  // read data gathered from the bank ports.
  logic [tim_bus_pkg::tim_data_bits-1:0] bank_rdata [tim_config_pkg::tim_width];

  // response stage.
  logic                                 valid_q;
  logic [tim_config_pkg::bank_bits-1:0] bank_q;

  // bits 1:0 pick the byte, bits 3:2 the bank, bits 9:4 the row.
  // anything above is ignored, so the memory aliases every 1 KB.
  assign bank_sel = req.addr[tim_config_pkg::bank_lsb +: tim_config_pkg::bank_bits];
  assign row_sel = req.addr[tim_config_pkg::row_lsb +: tim_config_pkg::row_bits];

  always_comb begin
    bank_en = '0;
    bank_en[bank_sel] = req.valid;  // one bank per request at most.
  end

  generate
    for (genvar i = 0; i < tim_config_pkg::tim_width; i++) begin : g_port
      assign banks[i].en = bank_en[i];
      assign banks[i].row = row_sel;
      assign banks[i].strb = bank_en[i] ? req.wstrb : '0;
      assign banks[i].wdata = req.wdata;
      assign bank_rdata[i] = banks[i].rdata;
    end
  endgenerate

  // remember which bank answers next cycle.
  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= 1'b0;
      bank_q <= '0;
    end else begin
      valid_q <= req.valid;
      if (req.valid) begin
        bank_q <= bank_sel;
      end
    end
  end

  // no gating of rdata here.
  // a bank that was not enabled on the last edge already returns zero.
  always_comb begin
    rsp.ready = valid_q;
    rsp.rdata = bank_rdata[bank_q];
  end

endmodule

// File: rtl/tim_top.sv
`timescale 1ns/10ps

module tim_top (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  tim_valid,
  input  logic [tim_bus_pkg::tim_addr_bits-1:0] tim_addr,
  input  logic [tim_bus_pkg::tim_data_bits-1:0] tim_wdata,
  input  logic [tim_bus_pkg::tim_strb_bits-1:0] tim_wstrb,
  output logic [tim_bus_pkg::tim_data_bits-1:0] tim_rdata,
  output logic                                  tim_ready
);

  tim_bus_pkg::tim_req_t req;
  tim_bus_pkg::tim_rsp_t rsp;

  // one port per bank.
  tim_bank_if banks [tim_config_pkg::tim_width] ();

  always_comb begin
    req.valid = tim_valid;
    req.addr = tim_addr;
    req.wdata = tim_wdata;
    req.wstrb = tim_wstrb;
  end

  always_comb begin
    tim_rdata = rsp.rdata;
    tim_ready = rsp.ready;
  end

  tim_ctrl u_ctrl (
    .clock (clock),
    .reset (reset),
    .req   (req),
    .rsp   (rsp),
    .banks (banks)
  );

  // interleaved banks, word i of a 16-byte line lives in bank i.
  generate
    for (genvar i = 0; i < tim_config_pkg::tim_width; i++) begin : g_bank
      tim_bank u_bank (
        .clock (clock),
        .port  (banks[i])
      );
    end
  endgenerate

endmodule

// File: tb/tim_assertions.sv
`timescale 1ns/10ps

module tim_assertions (
  input logic                                 clock,
  input logic                                 reset,
  input logic                                 valid,
  input logic [31:0]                          addr,
  input logic                                 ready,
  input logic [tim_config_pkg::tim_width-1:0] bank_en
);

  int failures = 0;  // read by the testbench.

  // the response comes exactly one cycle after its request.
  ready_follows_valid: assert property (
    @(posedge clock) $past(reset) |-> (ready == $past(valid))
  ) else begin
    $error("ready does not follow valid by one cycle");
    failures++;
  end

  // only the bank named by address bits 3:2 is enabled, and none when idle.
  bank_enable_decode: assert property (
    @(posedge clock) bank_en == (valid ? (4'b0001 << addr[3:2]) : 4'b0000)
  ) else begin
    $error("bank enables do not match the addressed bank");
    failures++;
  end

  ready_low_after_reset: assert property (@(posedge clock) !reset |=> !ready)
    else begin
      $error("ready is high in the cycle after reset");
      failures++;
    end

endmodule

bind tim_ctrl tim_assertions u_assertions (
  .clock   (clock),
  .reset   (reset),
  .valid   (req.valid),
  .addr    (req.addr),
  .ready   (rsp.ready),
  .bank_en (bank_en)
);

// File: tb/tim_checker.sv
`timescale 1ns/10ps

module tim_checker (
  input  logic        clock,
  input  logic        reset,
  input  logic        tim_valid,
  input  logic [31:0] tim_addr,
  input  logic [31:0] tim_wdata,
  input  logic [3:0]  tim_wstrb,
  input  logic [31:0] tim_rdata,
  input  logic        tim_ready,
  output int          checks,
  output int          errors
);

  // one word per location of the 1 KB window.
  logic [31:0] model [tim_config_pkg::tim_width * tim_config_pkg::tim_depth] =
    '{default: '0};

  logic        pend_valid = 1'b0;  // request taken on the last rising edge.
  logic [31:0] pend_addr;
  logic [31:0] pend_wdata;
  logic [3:0]  pend_wstrb;
  logic        armed = 1'b0;
  int          n_checks = 0;
  int          n_errors = 0;

  assign checks = n_checks;
  assign errors = n_errors;

  // bits 9:2 name the word, everything above aliases.
  function automatic int word_index(input logic [31:0] addr);
    return (addr >> 2) % (tim_config_pkg::tim_width * tim_config_pkg::tim_depth);
  endfunction

  always @(posedge clock) begin
    armed <= reset;
    if (!reset) begin
      pend_valid <= 1'b0;
    end else begin
      pend_valid <= tim_valid;
      pend_addr <= tim_addr;
      pend_wdata <= tim_wdata;
      pend_wstrb <= tim_wstrb;
    end
  end

  // outputs settle after the rising edge, so compare half a cycle later.
  always @(negedge clock) begin
    int          idx;
    logic [31:0] expected;
    if (armed) begin
      n_checks++;
      if (pend_valid) begin
        idx = word_index(pend_addr);
        expected = model[idx];  // word before the write.
        if (tim_ready !== 1'b1) begin
          $display("FAIL %0t ns: no ready for request to 0x%08h", $time, pend_addr);
          n_errors++;
        end else if (tim_rdata !== expected) begin
          $display("FAIL %0t ns: rdata 0x%08h at 0x%08h, expected 0x%08h",
                   $time, tim_rdata, pend_addr, expected);
          n_errors++;
        end
        for (int b = 0; b < 4; b++) begin
          if (pend_wstrb[b]) begin
            model[idx][8*b +: 8] = pend_wdata[8*b +: 8];
          end
        end
      end else if (tim_ready !== 1'b0 || tim_rdata !== 32'h0) begin
        $display("FAIL %0t ns: idle cycle shows ready %b rdata 0x%08h",
                 $time, tim_ready, tim_rdata);
        n_errors++;
      end
    end
  end

endmodule

// File: tb/tim_tb.sv
`timescale 1ns/10ps

module tim_tb;

  logic        clock;
  logic        reset;
  logic        tim_valid;
  logic [31:0] tim_addr;
  logic [31:0] tim_wdata;
  logic [3:0]  tim_wstrb;
  logic [31:0] tim_rdata;
  logic        tim_ready;
  int          checks;
  int          errors;

  int reset_cycles = 16;
  int test_cycles = 194;  // request and idle cycles of the six tests.
  int tests_run = 0;
  int checks_start;
  int errors_start;
  int asserts_start;

  tim_top UUT (
    .clock     (clock),
    .reset     (reset),
    .tim_valid (tim_valid),
    .tim_addr  (tim_addr),
    .tim_wdata (tim_wdata),
    .tim_wstrb (tim_wstrb),
    .tim_rdata (tim_rdata),
    .tim_ready (tim_ready)
  );

  tim_checker u_checker (
    .clock     (clock),
    .reset     (reset),
    .tim_valid (tim_valid),
    .tim_addr  (tim_addr),
    .tim_wdata (tim_wdata),
    .tim_wstrb (tim_wstrb),
    .tim_rdata (tim_rdata),
    .tim_ready (tim_ready),
    .checks    (checks),
    .errors    (errors)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic issue(input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [3:0] wstrb);
    @(negedge clock);
    tim_valid = 1'b1;
    tim_addr = addr;
    tim_wdata = wdata;
    tim_wstrb = wstrb;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      tim_valid = 1'b0;
      tim_addr = '0;
      tim_wdata = '0;
      tim_wstrb = '0;
    end
  endtask

  task automatic start_test();
    checks_start = checks;
    errors_start = errors;
    asserts_start = UUT.u_ctrl.u_assertions.failures;
  endtask

  task automatic finish_test(input string name);
    int found;
    idle(1);
    @(posedge clock);  // the last response was compared on the falling edge.
    tests_run++;
    found = (errors - errors_start) + (UUT.u_ctrl.u_assertions.failures - asserts_start);
    $display("test %0d %s: %0d checks, %0d errors", tests_run, name,
             checks - checks_start, found);
  endtask

  // random word among the low words of the window, with random upper bits.
  function automatic logic [31:0] window_addr(input int words);
    return ($urandom & 32'hffff_fc00) | (($urandom % words) << 2);
  endfunction

  initial begin : watchdog
    int limit;
    limit = 4 * (reset_cycles + test_cycles);
    #(limit * 40);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] addrs [16];
    logic [31:0] a;
    int          total;
    reset = 1'b0;
    tim_valid = 1'b0;
    tim_addr = '0;
    tim_wdata = '0;
    tim_wstrb = '0;
    void'($urandom(32'h1d40));
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b1;

    start_test();
    idle(20);
    finish_test("idle after reset");

    start_test();
    for (int i = 0; i < 16; i++) begin
      addrs[i] = window_addr(256);
      issue(addrs[i], $urandom, 4'hf);
    end
    for (int i = 0; i < 16; i++) begin
      issue(addrs[i] ^ ($urandom & 32'hffff_fc00), $urandom, 4'h0);
    end
    finish_test("full-word writes and read-back");

    start_test();
    for (int i = 0; i < 40; i++) begin
      issue(window_addr(16), $urandom, 4'($urandom));
    end
    for (int i = 0; i < 16; i++) begin
      issue(($urandom & 32'hffff_fc00) | (i << 2), $urandom, 4'h0);
    end
    finish_test("byte strobes");

    start_test();
    for (int i = 0; i < 32; i++) begin
      a = ($urandom & 32'hffff_fc00) | (($urandom % tim_config_pkg::tim_depth) << 4);
      a = a | ((i % tim_config_pkg::tim_width) << 2);  // walk through the banks.
      issue(a, $urandom, ($urandom % 3 == 0) ? 4'h0 : 4'($urandom));
    end
    finish_test("back-to-back across banks");

    start_test();
    for (int i = 0; i < 8; i++) begin
      a = window_addr(256);
      issue(a, $urandom, 4'hf);
      issue(a, $urandom, 4'hf);
      issue(a, $urandom, 4'(($urandom % 15) + 1));
    end
    finish_test("old word on write");

    start_test();
    for (int i = 0; i < 12; i++) begin
      a = window_addr(256);
      issue(a, $urandom, 4'hf);
      issue(a ^ (($urandom | 32'h400) & 32'hffff_fc00), 32'h0, 4'h0);
    end
    finish_test("address aliasing");

    total = errors + UUT.u_ctrl.u_assertions.failures;
    $display("%0d tests, %0d checks, %0d check errors, %0d assertion failures",
             tests_run, checks, errors, UUT.u_ctrl.u_assertions.failures);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
rtl/tim_config_pkg.sv
rtl/tim_bus_pkg.sv
rtl/tim_bank_if.sv
rtl/tim_bank.sv
rtl/tim_ctrl.sv
rtl/tim_top.sv
tb/tim_assertions.sv
tb/tim_checker.sv
tb/tim_tb.sv
